/* Makefile */
VERILATOR  := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_midget_ld
FILELIST   := midget_ld.f
OBJ_DIR    := obj_dir
PASS_MSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* design/csr_irq_regs.sv */
`default_nettype none

module csr_irq_regs import midget_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        csr_we,      // Single-cycle register write
   input  src_sel_e    csr_sel,     // Only MIE and MSTATUS are writable
   input  logic [31:0] csr_wdata,
   input  logic        irq_ext,     // Raw interrupt lines
   input  logic        irq_timer,
   input  logic        irq_sw,
   output irq_state_t  irq,
   output logic [31:0] mip_img,
   output logic [31:0] mie_img,
   output logic [31:0] mstatus_img
);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         irq <= '0;
      end else begin
         // Pending bits follow the lines one cycle late
         irq.meip <= irq_ext;
         irq.mtip <= irq_timer;
         irq.msip <= irq_sw;
         if (csr_we && csr_sel == src_mie) begin
            irq.meie <= csr_wdata[BIT_EXT];
            irq.mtie <= csr_wdata[BIT_TIMER];
            irq.msie <= csr_wdata[BIT_SW];
         end
         if (csr_we && csr_sel == src_mstatus) begin
            irq.mie  <= csr_wdata[MSTATUS_MIE];
            irq.mpie <= csr_wdata[MSTATUS_MPIE];
         end
         // Writes to MIP or the external code have no effect
      end
   end

   // Register images as seen by an IO read
   always_comb begin
      mip_img            = '0;
      mip_img[BIT_EXT]   = irq.meip;
      mip_img[BIT_TIMER] = irq.mtip;
      mip_img[BIT_SW]    = irq.msip;

      mie_img            = '0;
      mie_img[BIT_EXT]   = irq.meie;
      mie_img[BIT_TIMER] = irq.mtie;
      mie_img[BIT_SW]    = irq.msie;

      mstatus_img               = MSTATUS_MPP; // Bits 12:11 always one
      mstatus_img[MSTATUS_MPIE] = irq.mpie;
      mstatus_img[MSTATUS_MIE]  = irq.mie;
   end

endmodule

`default_nettype wire

/* design/input_mux.sv */
`default_nettype none

module input_mux import midget_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        capture, // Load theio into rdee
   input  logic        sa00,    // Main select, forces merge next cycle
   input  logic        any_ack, // Any of the three acknowledges
   input  logic [31:0] theio,
   input  logic [31:0] dat_o,   // EBR output, also the merge mask
   input  rd_req_t     cur,
   output logic [31:0] rdee,
   output logic [31:0] di
);

   logic        merge;
   logic [31:0] sh_adr;

   // Arithmetic-style right shift with chosen top bit
   assign sh_adr = {cur.sra_msb, cur.adr[31:1]};

   // Capture register for the read word
   always_ff @(posedge clk) begin
      if (capture) begin
         rdee <= theio;
      end
   end

   // Merge select, reloaded every edge
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         merge <= 1'b0;
      end else begin
         merge <= any_ack | sa00;
      end
   end

   // Where dat_o is one take rdee, else the shifted address
   assign di = merge ? ((dat_o & rdee) | (~dat_o & sh_adr)) : dat_o;

endmodule

`default_nettype wire

/* design/io_read_sel.sv */
`default_nettype none

module io_read_sel import midget_pkg::*; #(
   parameter int IWIDTH     = 8, // External port width, 8, 16 or 32
   parameter bit HAS_SYSREG = 1  // Map MIP, MIE and MSTATUS into IO space
) (
   input  logic              stb,
   input  rd_req_t           cur,
   input  logic [IWIDTH-1:0] dat_i,       // External data port
   input  logic [31:0]       dsram,       // SRAM read word
   input  logic [31:0]       mip_img,
   input  logic [31:0]       mie_img,
   input  logic [31:0]       mstatus_img,
   output logic [31:0]       theio,       // Selected word
   output logic              sysregack
);

   logic [31:0] ext_word;
   logic [31:0] io_word;

   assign ext_word = 32'(dat_i); // Zero-extended external port

   generate
      if (HAS_SYSREG) begin : g_sysreg
         src_sel_e src;

         assign src = src_sel_e'(cur.adr[29:28]);

         always_comb begin
            case (src)
               src_mip:     io_word = mip_img;
               src_mie:     io_word = mie_img;
               src_mstatus: io_word = mstatus_img;
               default:     io_word = ext_word; // src_ext
            endcase
         end

         // Registers answer at once, in the first strobe cycle
         assign sysregack = stb && cur.io && (src != src_ext);
      end else begin : g_no_sysreg
         // Whole IO region is the external port
         assign io_word   = ext_word;
         assign sysregack = 1'b0;
      end
   endgenerate

   assign theio = cur.io ? io_word : dsram;

endmodule

`default_nettype wire

/* design/ld_ctrl.sv */
`default_nettype none

module ld_ctrl import midget_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    req,       // One-cycle request pulse
   input  rd_req_t req_in,    // Request payload, valid with req
   input  logic    ack_i,     // External IO acknowledge
   input  logic    sram_ack,  // SRAM acknowledge
   input  logic    sysregack, // System register acknowledge
   output logic    stb,       // Bus strobe, level
   output logic    done,      // One cycle after the closing acknowledge
   output logic    capture,   // Load strobe for the read word
   output logic    busy,
   output rd_req_t cur        // Latched request
);

   ld_state_e state;
   ld_state_e state_nxt;
   logic      close_ack;

   // IO reads end on the external or system-register ack,
   // memory reads only on the SRAM ack
   assign close_ack = cur.io ? (ack_i | sysregack) : sram_ack;

   always_comb begin
      state_nxt = state;
      case (state)
         idle: begin
            if (req) begin
               state_nxt = bus;
            end
         end
         bus: begin
            if (close_ack) begin
               state_nxt = deliver;
            end
         end
         deliver: begin
            state_nxt = idle; // Done lasts exactly one cycle
         end
         default: begin
            state_nxt = idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= idle;
      end else begin
         state <= state_nxt;
      end
   end

   // Request only taken in idle, a req while busy is dropped
   always_ff @(posedge clk) begin
      if (state == idle && req) begin
         cur <= req_in;
      end
   end

   assign stb     = (state == bus);
   assign capture = (state == bus) && close_ack; // Same cycle as the ack
   assign done    = (state == deliver);
   assign busy    = (state != idle);

endmodule

`default_nettype wire

/* design/midget_ld_top.sv */
`default_nettype none

module midget_ld_top import midget_pkg::*; #(
   parameter int IWIDTH     = 8, // External data port width
   parameter bit HAS_SYSREG = 1  // System registers in IO space
) (
   input  logic              clk,
   input  logic              rst_n,
   // Read request
   input  logic              req,
   input  rd_req_t           req_in,
   // Bus side
   input  logic              ack_i,
   input  logic              sram_ack,
   input  logic [IWIDTH-1:0] dat_i,
   input  logic [31:0]       dsram,
   // Core side
   input  logic [31:0]       dat_o,
   input  logic              sa00,
   // Register writes and interrupt lines
   input  logic              csr_we,
   input  src_sel_e          csr_sel,
   input  logic [31:0]       csr_wdata,
   input  logic              irq_ext,
   input  logic              irq_timer,
   input  logic              irq_sw,
   output logic              stb,
   output logic              done,
   output logic              busy,
   output logic [31:0]       rdee,
   output logic [31:0]       di,
   output logic              sysregack
);

   rd_req_t     cur;
   logic        capture;
   logic        any_ack;
   logic [31:0] theio;
   logic [31:0] mip_img;
   logic [31:0] mie_img;
   logic [31:0] mstatus_img;

   assign any_ack = ack_i | sram_ack | sysregack;

   ld_ctrl u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .req_in    (req_in),
      .ack_i     (ack_i),
      .sram_ack  (sram_ack),
      .sysregack (sysregack),
      .stb       (stb),
      .done      (done),
      .capture   (capture),
      .busy      (busy),
      .cur       (cur)
   );

   csr_irq_regs u_csr (
      .clk         (clk),
      .rst_n       (rst_n),
      .csr_we      (csr_we),
      .csr_sel     (csr_sel),
      .csr_wdata   (csr_wdata),
      .irq_ext     (irq_ext),
      .irq_timer   (irq_timer),
      .irq_sw      (irq_sw),
      .irq         (), // Raw state goes to the trap logic, not part of this path
      .mip_img     (mip_img),
      .mie_img     (mie_img),
      .mstatus_img (mstatus_img)
   );

   io_read_sel #(
      .IWIDTH     (IWIDTH),
      .HAS_SYSREG (HAS_SYSREG)
   ) u_sel (
      .stb         (stb),
      .cur         (cur),
      .dat_i       (dat_i),
      .dsram       (dsram),
      .mip_img     (mip_img),
      .mie_img     (mie_img),
      .mstatus_img (mstatus_img),
      .theio       (theio),
      .sysregack   (sysregack)
   );

   input_mux u_mux (
      .clk     (clk),
      .rst_n   (rst_n),
      .capture (capture),
      .sa00    (sa00),
      .any_ack (any_ack),
      .theio   (theio),
      .dat_o   (dat_o),
      .cur     (cur),
      .rdee    (rdee),
      .di      (di)
   );

endmodule

`default_nettype wire

/* design/midget_pkg.sv */
`default_nettype none

package midget_pkg;

   // One read request as latched by the control block
   typedef struct packed {
      logic        io;      // 1 selects IO region, 0 selects SRAM
      logic [31:0] adr;     // Byte address
      logic        sra_msb; // Bit shifted in at the top of the shifted address
   } rd_req_t;

   // Stored interrupt state, global enables first
   typedef struct packed {
      logic mie;  // Global enable
      logic mpie; // Previous global enable
      logic meie; // External enable
      logic mtie; // Timer enable
      logic msie; // Software enable
      logic meip; // External pending
      logic mtip; // Timer pending
      logic msip; // Software pending
   } irq_state_t;

   // Control FSM states
   typedef enum logic [1:0] {
      idle    = 2'd0,
      bus     = 2'd1,
      deliver = 2'd2
   } ld_state_e;

   // Source codes, equal to address bits 29..28 of an IO read
   typedef enum logic [1:0] {
      src_ext     = 2'd0,
      src_mip     = 2'd1,
      src_mie     = 2'd2,
      src_mstatus = 2'd3
   } src_sel_e;

   // Interrupt bit positions shared by MIP and MIE
   localparam int unsigned BIT_SW    = 3;
   localparam int unsigned BIT_TIMER = 7;
   localparam int unsigned BIT_EXT   = 11;

   // MSTATUS layout
   localparam int unsigned MSTATUS_MIE  = 3;
   localparam int unsigned MSTATUS_MPIE = 7;
   localparam logic [31:0] MSTATUS_MPP  = 32'h0000_1800; // MPP reads as machine mode

endpackage

`default_nettype wire

/* midget_ld.f */
design/midget_pkg.sv
design/ld_ctrl.sv
design/csr_irq_regs.sv
design/io_read_sel.sv
design/input_mux.sv
design/midget_ld_top.sv
tb/midget_ld_assert.sv
tb/tb_midget_ld.sv

/* tb/midget_ld_assert.sv */
`default_nettype none

module midget_ld_assert import midget_pkg::*; (
   input logic      clk,
   input logic      rst_n,
   input logic      stb,
   input logic      done,
   input logic      close_ack, // Acknowledge that ends the current access
   input ld_state_e state
);

   // Done is a single-cycle pulse
   a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
      else $error("done high for more than one cycle");

   // No strobe while the FSM waits for a request
   a_idle_stb: assert property (@(posedge clk) disable iff (!rst_n) (state == idle) |-> !stb)
      else $error("stb high in idle");

   a_stb_fall: assert property (@(posedge clk) disable iff (!rst_n)
      (stb && close_ack) |=> !stb)
      else $error("stb still high after the closing acknowledge");

endmodule

`default_nettype wire

/* tb/tb_midget_ld.sv */
`default_nettype none

module tb_midget_ld import midget_pkg::*;;

   localparam int PERIOD    = 8;
   localparam int NROWS     = 14;
   localparam int MAX_DLY   = 6;                          // Longest ack delay in the table
   localparam int WD_CYCLES = NROWS * (MAX_DLY + 8) + 20;  // Watchdog budget

   typedef enum logic [2:0] {op_ext, op_sys, op_sram, op_csr, op_irq} op_e;

   typedef struct packed {
      op_e         op;
      logic [31:0] adr;      // Bits 29..28 also carry the CSR select
      logic        sra_msb;
      logic [31:0] wdata;    // CSR data, IRQ lines or read data
      logic [2:0]  dly;      // Cycles from stb to the acknowledge
      logic        noise;    // Stray req and wrong-type ack during the access
      logic [31:0] dat_o;
      logic [31:0] exp_rdee;
      logic [31:0] exp_di;
   } row_t;

   logic        clk;
   logic        rst_n;
   logic        req;
   rd_req_t     req_in;
   logic        ack_i;
   logic        sram_ack;
   logic [7:0]  dat_i;
   logic [31:0] dsram;
   logic [31:0] dat_o;
   logic        sa00;
   logic        csr_we;
   src_sel_e    csr_sel;
   logic [31:0] csr_wdata;
   logic        irq_ext;
   logic        irq_timer;
   logic        irq_sw;
   logic        stb;
   logic        done;
   logic        busy;
   logic [31:0] rdee;
   logic [31:0] di;
   logic        sysregack;

   row_t        tbl [NROWS];
   int          nrows;
   int          errors;
   int          checks;
   logic [31:0] lfsr;
   logic [31:0] mie_m;   // Reference register images
   logic [31:0] mst_m;
   logic [31:0] mip_m;

   midget_ld_top #(.IWIDTH(8), .HAS_SYSREG(1)) dut (.*);

   bind ld_ctrl midget_ld_assert u_assert (
      .clk(clk), .rst_n(rst_n), .stb(stb), .done(done),
      .close_ack(close_ack), .state(state)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Fill one row and track what the register images should hold
   task automatic add_row(input op_e op, input logic [1:0] sel, input logic noise);
      row_t r;
      r       = '0;
      r.op    = op;
      r.noise = noise;
      case (op)
         op_csr: begin
            r.adr[29:28] = sel;
            r.wdata      = rand_bits(32);
            if (sel == src_mie) mie_m = r.wdata & 32'h0000_0888;            // Bits 11, 7, 3
            else mst_m = 32'h0000_1800 | (r.wdata & 32'h0000_0088); // MPP plus bits 7, 3
         end
         op_irq: begin
            r.wdata = rand_bits(3);           // {ext, timer, sw}
            mip_m   = {20'b0, r.wdata[2], 3'b0, r.wdata[1], 3'b0, r.wdata[0], 3'b0};
         end
         default: begin
            r.adr     = rand_bits(32);
            r.sra_msb = 1'(rand_bits(1));
            r.dat_o   = rand_bits(32);
            r.dly     = noise ? 3'd3 + 3'(rand_bits(2)) : 3'd1 + 3'(rand_bits(2));
            if (op != op_sram) r.adr[29:28] = sel;
            if (op == op_ext) begin
               r.wdata    = rand_bits(8);
               r.exp_rdee = {24'b0, r.wdata[7:0]};  // Zero-extended port
            end else if (op == op_sram) begin
               r.wdata    = rand_bits(32);
               r.exp_rdee = r.wdata;
            end else begin
               r.exp_rdee = (sel == src_mip) ? mip_m : (sel == src_mie) ? mie_m : mst_m;
            end
            // rdee where dat_o is one, shifted address where zero
            r.exp_di = (r.dat_o & r.exp_rdee) | (~r.dat_o & {r.sra_msb, r.adr[31:1]});
         end
      endcase
      tbl[nrows] = r;
      nrows++;
   endtask

   task automatic write_csr(input row_t r);
      csr_we    = 1'b1;
      csr_sel   = src_sel_e'(r.adr[29:28]);
      csr_wdata = r.wdata;
      @(negedge clk);
      csr_we    = 1'b0;
   endtask

   task automatic drive_irq(input row_t r);
      {irq_ext, irq_timer, irq_sw} = r.wdata[2:0];
      repeat (2) @(negedge clk);  // Lines stay at this level afterwards
   endtask

   // One read from request to done, then the idle cycles that follow
   task automatic run_read(input row_t r);
      logic io;
      int   cyc;
      int   ndone;
      io     = (r.op != op_sram);
      req    = 1'b1;
      req_in = {io, r.adr, r.sra_msb};
      dat_o  = r.dat_o;
      dat_i  = io ? r.wdata[7:0] : ~r.wdata[7:0];
      dsram  = io ? ~r.wdata : r.wdata;
      @(negedge clk);
      req = 1'b0;
      cyc = 1;
      while (!done && cyc <= MAX_DLY + 2) begin
         check("stb", 32'(stb), 32'd1);
         check("busy", 32'(busy), 32'd1);
         check("sysregack", 32'(sysregack), 32'(r.op == op_sys));
         if (r.noise && cyc == 1) begin
            req    = 1'b1;                                   // Dropped by the FSM
            req_in = {~io, r.adr ^ 32'h3000_0000, r.sra_msb};
            if (io) sram_ack = 1'b1;
            else ack_i = 1'b1;                          // Must not close an SRAM access
         end
         if (r.op != op_sys && cyc == int'(r.dly)) begin
            if (io) ack_i = 1'b1;
            else sram_ack = 1'b1;
         end
         @(negedge clk);
         req      = 1'b0;
         ack_i    = 1'b0;
         sram_ack = 1'b0;
         cyc++;
      end
      if (!done) begin
         $display("Read at %h never reached done within %0d cycles", r.adr, MAX_DLY + 2);
         errors++;
         return;
      end
      check("rdee", rdee, r.exp_rdee);
      check("di", di, r.exp_di);
      ndone = 1;
      @(negedge clk);
      check("di_idle", di, r.dat_o);  // Merge register low again
      check("busy", 32'(busy), 32'd0);
      if (done) ndone++;
      repeat (2) begin
         @(negedge clk);
         if (done) ndone++;
      end
      check("done_count", ndone, 32'd1);
   endtask

   initial begin
      #(WD_CYCLES * PERIOD);
      $display("Watchdog expired after %0d cycles, run did not finish", WD_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      int err_before;
      rst_n     = 1'b0;
      req       = 1'b0;
      req_in    = '0;
      ack_i     = 1'b0;
      sram_ack  = 1'b0;
      dat_i     = '0;
      dsram     = '0;
      sa00      = 1'b0;
      csr_we    = 1'b0;
      csr_sel   = src_ext;
      csr_wdata = '0;
      irq_ext   = 1'b0;
      irq_timer = 1'b0;
      irq_sw    = 1'b0;
      errors    = 0;
      checks    = 0;
      nrows     = 0;
      lfsr      = 32'he8b9;
      mie_m     = '0;
      mst_m     = 32'h0000_1800;
      mip_m     = '0;
      dat_o     = rand_bits(32);

      add_row(op_csr,  src_mie,     1'b0);
      add_row(op_csr,  src_mstatus, 1'b0);
      add_row(op_sys,  src_mie,     1'b0);
      add_row(op_sys,  src_mstatus, 1'b0);
      add_row(op_irq,  src_ext,     1'b0);
      add_row(op_sys,  src_mip,     1'b0);
      add_row(op_ext,  src_ext,     1'b0);
      add_row(op_sram, src_ext,     1'b1);
      add_row(op_ext,  src_ext,     1'b1);
      add_row(op_sram, src_ext,     1'b0);
      add_row(op_irq,  src_ext,     1'b0);
      add_row(op_sys,  src_mip,     1'b0);
      add_row(op_ext,  src_ext,     1'b0);
      add_row(op_sram, src_ext,     1'b0);

      repeat (2) @(posedge clk);  // Two reset edges
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check("stb", 32'(stb), 32'd0);
      check("done", 32'(done), 32'd0);
      check("busy", 32'(busy), 32'd0);
      check("di", di, dat_o);  // Idle with sa00 low passes dat_o through

      for (int i = 0; i < nrows; i++) begin
         err_before = errors;
         case (tbl[i].op)
            op_csr:  write_csr(tbl[i]);
            op_irq:  drive_irq(tbl[i]);
            default: run_read(tbl[i]);
         endcase
         $display("Row %0d %s adr %h: %s", i, tbl[i].op.name(), tbl[i].adr,
                  (errors == err_before) ? "ok" : "mismatch");
      end

      $display("%0d rows, %0d checks, %0d errors", nrows, checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
